//--- rtl/fp64_macros.svh
// width and bias macros for the IEEE 754 double format
`ifndef FP64_MACROS_SVH
`define FP64_MACROS_SVH

// ============================================================
// double precision layout  sign | exp[10:0] | sig[51:0]
// ============================================================

`define FPWID     64      // whole word
`define MSB       63      // top bit of the word
`define EMSB      10      // top bit of exponent field, 11 bits
`define FMSB      51      // top bit of fraction field, 52 bits

// exponent bias, biased 0 is zero/denormal, all ones is inf/nan
`define EXP_BIAS  1023

`endif

//--- rtl/fp64Pkg.sv
// FP64 field struct, FP64Word union and the shared round-increment function
package fp64Pkg;

`include "fp64_macros.svh"

// ============================================================
// types
// ============================================================

typedef struct packed {
	logic sign;                 // 1 = negative
	logic [`EMSB:0] exp;        // biased exponent
	logic [`FMSB:0] sig;        // fraction, leading one hidden
} FP64;

// one word, read by fields for a double or raw for an integer
typedef union packed {
	FP64 fp;
	logic [`MSB:0] raw;
} FP64Word;

// round increment shared by both directions
// neg is the sign of the value, lsb/rb/sb are the kept lsb, round and sticky bits
function automatic logic rndUp(input logic [2:0] rm, input logic neg, input logic lsb,
	input logic rb, input logic sb);
	case (rm)
	3'd1:    rndUp = 1'b0;               // toward zero, truncate
	3'd2:    rndUp = (rb | sb) & ~neg;   // toward +inf
	3'd3:    rndUp = (rb | sb) & neg;    // toward -inf
	3'd4:    rndUp = rb | sb;            // away from zero
	default: rndUp = rb & (lsb | sb);    // nearest even, also codes 5..7
	endcase
endfunction

endpackage

//--- rtl/cntlz64Reg.sv
// cntlz64Reg: registered 64-bit leading-zero counter
`timescale 1ns/10ps
`include "fp64_macros.svh"

module cntlz64Reg (
	input  logic clk,
	input  logic rstN,
	input  logic ce,
	input  logic [`FPWID-1:0] i,
	output logic [6:0] o            // 0..64
);

logic [6:0] cnt;

// leading zeros of one 16-bit group, 16 when the group is empty
function automatic logic [4:0] lz16(input logic [15:0] v);
	logic [4:0] n;
	logic hit;
	integer k;
	n = 5'd16;
	hit = 1'b0;
	for (k = 15; k >= 0; k = k - 1) begin
		if (!hit && v[k]) begin
			n = 5'(15 - k);     // first one from the top
			hit = 1'b1;
		end
	end
	lz16 = n;
endfunction

// priority over the four groups, top group first
always_comb begin
	if (|i[63:48])       cnt = {2'b00, lz16(i[63:48])};
	else if (|i[47:32])  cnt = 7'd16 + {2'b00, lz16(i[47:32])};
	else if (|i[31:16])  cnt = 7'd32 + {2'b00, lz16(i[31:16])};
	else if (|i[15:0])   cnt = 7'd48 + {2'b00, lz16(i[15:0])};
	else                 cnt = 7'd64;   // all zero
end

always_ff @(posedge clk) begin
	if (!rstN)
		o <= '0;
	else if (ce)
		o <= cnt;
end

endmodule

//--- rtl/fpCvtI64To64.sv
// fpCvtI64To64: signed/unsigned 64-bit integer to double, one cycle
`timescale 1ns/10ps
`include "fp64_macros.svh"

module fpCvtI64To64 (
	input  logic clk,
	input  logic rstN,
	input  logic ce,
	input  logic op,                // 1 = signed input
	input  logic [2:0] rm,          // rounding mode
	input  logic [`MSB:0] i,        // integer operand
	output fp64Pkg::FP64 o,         // double result
	output logic inexact
);

import fp64Pkg::*;

// exponent of a value whose leading one sits in bit 63
localparam logic [`EMSB:0] ExpTop = `EXP_BIAS + `MSB;

logic [`MSB:0] magIn;               // magnitude before the register
logic [2:0] rmReg;
logic nzReg;                        // nonzero input, clears to zero
logic negReg;                       // signed and negative
logic [`MSB:0] magReg;
logic [6:0] lz;                     // leading zeros of magReg

logic [`MSB:0] simag;               // left aligned magnitude
logic gb, rb, sb, rnd;
logic [`FMSB+1:0] fracSum;          // fraction plus carry
logic [`EMSB:0] expBase;
FP64 res;

// ============================================================
// input register rank
// ============================================================

assign magIn = (op & i[`MSB]) ? -i : i;     // two's complement negate

always_ff @(posedge clk) begin
	if (!rstN) begin
		rmReg <= '0;
		nzReg <= 1'b0;
		negReg <= 1'b0;
		magReg <= '0;
	end else if (ce) begin
		rmReg <= rm;
		nzReg <= |i;
		negReg <= op & i[`MSB];
		magReg <= magIn;
	end
end

// count comes out of its own register on the same edge
cntlz64Reg lzCnt (
	.clk(clk),
	.rstN(rstN),
	.ce(ce),
	.i(magIn),
	.o(lz)
);

// ============================================================
// normalize and round
// ============================================================

assign simag = magReg << lz;                // leading one now in bit 63

// 52 fraction bits are simag[62:11], everything below gets rounded away
assign gb = simag[`EMSB+1];                 // lsb kept
assign rb = simag[`EMSB];                   // first bit dropped
assign sb = |simag[`EMSB-1:0];              // rest of the dropped bits
assign rnd = rndUp(rmReg, negReg, gb, rb, sb);

assign fracSum = {1'b0, simag[`MSB-1:`EMSB+1]} + {{(`FMSB+1){1'b0}}, rnd};
assign expBase = ExpTop - {4'b0000, lz};

always_comb begin
	res.sign = negReg;
	res.sig = fracSum[`FMSB:0];             // wraps to 0 on carry out
	if (nzReg)
		res.exp = expBase + {{`EMSB{1'b0}}, fracSum[`FMSB+1]};  // carry bumps exp
	else
		res.exp = '0;                       // +0.0
end

assign o = res;
assign inexact = rb | sb;                   // 0 for zero input, simag is 0

endmodule

//--- rtl/fpCvt64ToI64.sv
// fpCvt64ToI64: double to signed/unsigned 64-bit integer with rounding and saturation
`timescale 1ns/10ps
`include "fp64_macros.svh"

module fpCvt64ToI64 (
	input  logic clk,
	input  logic rstN,
	input  logic ce,
	input  logic op,                // 1 = signed result
	input  logic [2:0] rm,          // rounding mode
	input  fp64Pkg::FP64 i,         // double operand
	output logic [`MSB:0] o,        // integer result
	output logic inexact,
	output logic invalid,
	output logic overflow
);

import fp64Pkg::*;

// biased exponents of interest
localparam logic [`EMSB:0] ExpInt = `EXP_BIAS + `FMSB + 1;  // 2^52, no fraction left
localparam logic [`EMSB:0] ExpBig = `EXP_BIAS + `MSB + 1;   // 2^64, always out of range
localparam logic [`EMSB:0] ExpMin = ExpInt - 11'd64;        // right shift clamps at 64

FP64 opReg;
logic opdReg;
logic [2:0] rmReg;

logic [`FMSB+1:0] man;              // significand with hidden bit
logic isNan, bigExp, leftPath;
logic [3:0] lsh;                    // left shift 0..11
logic [6:0] rsh;                    // right shift 1..64
logic [2*`FPWID-1:0] wide;          // integer part over 64 fraction bits
logic [`MSB:0] intPart;
logic rb, sb, rnd;
logic [`FPWID:0] magR;              // rounded magnitude plus carry
logic posOvf, negOvf, rangeErr;
logic [`MSB:0] satVal;

// ============================================================
// operand register rank
// ============================================================

always_ff @(posedge clk) begin
	if (!rstN) begin
		opReg <= '0;                // +0.0
		opdReg <= 1'b0;
		rmReg <= '0;
	end else if (ce) begin
		opReg <= i;
		opdReg <= op;
		rmReg <= rm;
	end
end

// ============================================================
// alignment
// ============================================================

assign man = {|opReg.exp, opReg.sig};       // denormals have no hidden one
assign isNan = (&opReg.exp) & (|opReg.sig);
assign bigExp = opReg.exp >= ExpBig;        // inf lands here too
assign leftPath = opReg.exp >= ExpInt;

assign lsh = 4'(opReg.exp - ExpInt);        // only read on the left path
assign rsh = (opReg.exp < ExpMin) ? 7'd64 : 7'(ExpInt - opReg.exp);

// below 2^-1 everything is sticky, so clamping at 64 loses nothing
assign wide = {{(`MSB-`FMSB-1){1'b0}}, man, {`FPWID{1'b0}}} >> rsh;

assign intPart = leftPath ? ({{(`MSB-`FMSB-1){1'b0}}, man} << lsh) : wide[2*`FPWID-1:`FPWID];
assign rb = ~leftPath & wide[`MSB];
assign sb = ~leftPath & (|wide[`MSB-1:0]);

// ============================================================
// round and range check
// ============================================================

assign rnd = rndUp(rmReg, opReg.sign, intPart[0], rb, sb);
assign magR = {1'b0, intPart} + {{`FPWID{1'b0}}, rnd};

// signed: pos limit 2^63-1, neg limit 2^63; unsigned: neg limit 0
assign posOvf = opdReg ? (|magR[`FPWID:`MSB]) : magR[`FPWID];
assign negOvf = opdReg ? (magR > {2'b01, {`MSB{1'b0}}}) : (|magR);
assign rangeErr = bigExp | (opReg.sign ? negOvf : posOvf);

always_comb begin
	if (opdReg)
		satVal = opReg.sign ? {1'b1, {`MSB{1'b0}}} : {1'b0, {`MSB{1'b1}}};
	else
		satVal = opReg.sign ? '0 : '1;
end

always_comb begin
	o = opReg.sign ? -magR[`MSB:0] : magR[`MSB:0];
	inexact = rb | sb;
	invalid = 1'b0;
	overflow = 1'b0;
	if (isNan) begin
		o = opdReg ? {1'b0, {`MSB{1'b1}}} : '1;    // positive max
		inexact = 1'b0;
		invalid = 1'b1;
	end else if (rangeErr) begin
		o = satVal;                                 // saturate toward the sign
		inexact = 1'b0;
		invalid = 1'b1;
		overflow = 1'b1;
	end
end

endmodule

//--- rtl/fpCvtUnit.sv
// fpCvtUnit: two-way 64-bit integer/double converter with registered direction select
`timescale 1ns/10ps
`include "fp64_macros.svh"

module fpCvtUnit (
	input  logic clk,
	input  logic rstN,
	input  logic ce,
	input  logic dir,               // 0 = int to double, 1 = double to int
	input  logic op,                // 1 = signed integer side
	input  logic [2:0] rm,
	input  logic [`MSB:0] i,
	output fp64Pkg::FP64Word o,
	output logic inexact,
	output logic invalid,
	output logic overflow
);

import fp64Pkg::*;

FP64Word inWord;
FP64 fltRes;                        // int to double result
logic [`MSB:0] intRes;              // double to int result
logic i2fInexact, f2iInexact, f2iInvalid, f2iOverflow;
logic dirReg;
FP64Word res;

assign inWord.raw = i;              // same bits, double view for the reverse path

// ============================================================
// both converters always run
// ============================================================

fpCvtI64To64 i2f (
	.clk(clk),
	.rstN(rstN),
	.ce(ce),
	.op(op),
	.rm(rm),
	.i(i),
	.o(fltRes),
	.inexact(i2fInexact)
);

fpCvt64ToI64 f2i (
	.clk(clk),
	.rstN(rstN),
	.ce(ce),
	.op(op),
	.rm(rm),
	.i(inWord.fp),
	.o(intRes),
	.inexact(f2iInexact),
	.invalid(f2iInvalid),
	.overflow(f2iOverflow)
);

// direction follows its operand through the register rank
always_ff @(posedge clk) begin
	if (!rstN)
		dirReg <= 1'b0;
	else if (ce)
		dirReg <= dir;
end

// result mux
always_comb begin
	if (dirReg)
		res.raw = intRes;           // integer, raw view
	else
		res.fp = fltRes;            // double, field view
end

assign o = res;
assign inexact = dirReg ? f2iInexact : i2fInexact;
assign invalid = dirReg & f2iInvalid;      // never set int to double
assign overflow = dirReg & f2iOverflow;

endmodule

//--- tests/fpCvtUnit_properties.sv
// structural concurrent assertions for fpCvtUnit and their bind
`timescale 1ns/10ps
`include "fp64_macros.svh"

module fpCvtUnit_properties (
	input logic clk,
	input logic rstN,
	input logic ce,
	input logic dirReg,               // registered direction inside the DUT
	input logic [`MSB:0] o,
	input logic inexact,
	input logic invalid,
	input logic overflow
);

// ============================================================
// reset and hold
// ============================================================

// every register clears, so all outputs read zero
zeroAfterReset: assert property (@(posedge clk)
	!rstN |=> (o == '0) && !inexact && !invalid && !overflow)
	else $error("outputs not zero after reset");

// no ce, no change
holdWithoutCe: assert property (@(posedge clk) disable iff (!rstN)
	!ce |=> $stable(o) && $stable(inexact) && $stable(invalid) && $stable(overflow))
	else $error("outputs changed while ce was low");

// ============================================================
// flag rules
// ============================================================

// int to double never flags invalid or overflow
noRangeFlagsI2f: assert property (@(posedge clk) !dirReg |-> !invalid && !overflow)
	else $error("range flag set in int to double direction");

overflowIsInvalid: assert property (@(posedge clk) overflow |-> invalid)
	else $error("overflow set without invalid");

endmodule

bind fpCvtUnit fpCvtUnit_properties fpCvtUnitProps (
	.clk(clk),
	.rstN(rstN),
	.ce(ce),
	.dirReg(dirReg),
	.o(o),
	.inexact(inexact),
	.invalid(invalid),
	.overflow(overflow)
);

//--- tests/fpCvtUnit_tb.sv
// clock, reset, LFSR stimulus, reference models, checks and watchdog for the fpCvtUnit testbench
`timescale 1ns/10ps
`include "fp64_macros.svh"

module fpCvtUnit_tb;

import fp64Pkg::*;

localparam int ClkPeriod = 4;
localparam int RoundPerMode = 20;         // random ints per rounding mode
localparam int RangePerCase = 6;          // random doubles per rm/op pair
localparam int AltCycles = 16;
localparam int RunCycles = 5 + 30 + (8 * RoundPerMode + 8) + (16 * RangePerCase + 4) + 20
	+ (AltCycles + 4) + 20;

logic clk, rstN, ce, dir, op;
logic [2:0] rm;
logic [`MSB:0] i;
FP64Word o;
logic inexact, invalid, overflow;

logic [31:0] lfsr = 32'h7c90_ad58;
int errCount = 0;
int testErrBase = 0;
int passCount = 0;
int failCount = 0;

// expected response latched on each ce edge
logic chkValid;
logic [`MSB:0] expO;
logic expInexact, expInvalid, expOverflow;
FP64Word rndW;
int k, m, n;

fpCvtUnit fpCvtUnit_inst (
	.clk(clk), .rstN(rstN), .ce(ce), .dir(dir), .op(op), .rm(rm), .i(i),
	.o(o), .inexact(inexact), .invalid(invalid), .overflow(overflow)
);

initial begin
	clk = 1'b0;
	forever #(ClkPeriod / 2) clk = ~clk;
end

// ============================================================
// random numbers and reference models
// ============================================================

function automatic logic [31:0] lfsrStep(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one LFSR step per bit taken
function automatic logic [63:0] randBits(input int nb);
	logic [63:0] r;
	int b;
	r = '0;
	for (b = 0; b < nb; b++) begin
		lfsr = lfsrStep(lfsr);
		r = {r[62:0], lfsr[0]};
	end
	return r;
endfunction

// rem falls below the kept lsb and half weighs half an lsb
function automatic logic roundsUp(input logic [2:0] mode, input logic neg, input logic odd,
	input logic [127:0] rem, input logic [127:0] half);
	case (mode)
	3'd1: return 1'b0;
	3'd2: return (rem != 0) & ~neg;
	3'd3: return (rem != 0) & neg;
	3'd4: return rem != 0;
	default: return (rem > half) || ((rem == half) && odd);
	endcase
endfunction

// {inexact, double}
function automatic logic [64:0] i2fModel(input logic sgn, input logic [2:0] mode,
	input logic [63:0] x);
	FP64Word w;
	logic neg, up;
	logic [63:0] mag, kept, rem, half;
	int p, s, b;
	neg = sgn & x[63];
	mag = neg ? -x : x;
	w.raw = '0;
	p = -1;
	for (b = 0; b < 64; b++) begin
		if (mag[b])
			p = b;                     // top one wins
	end
	if (p < 0)
		return 65'd0;
	if (p <= `FMSB + 1) begin
		kept = mag << (`FMSB + 1 - p);  // fits exactly
		rem = '0;
		half = 64'd1;
	end else begin
		s = p - `FMSB - 1;
		kept = mag >> s;
		rem = mag & ((64'd1 << s) - 1);
		half = 64'd1 << (s - 1);
	end
	up = roundsUp(mode, neg, kept[0], {64'd0, rem}, {64'd0, half});
	kept = kept + {63'd0, up};
	w.fp.sign = neg;
	w.fp.exp = 11'(`EXP_BIAS + p);
	if (kept[`FMSB + 2]) begin         // carried into 2^53
		kept = kept >> 1;
		w.fp.exp = w.fp.exp + 11'd1;
	end
	w.fp.sig = kept[`FMSB:0];
	return {rem != 0, w.raw};
endfunction

// {inexact, invalid, overflow, integer}
function automatic logic [66:0] f2iModel(input logic sgn, input logic [2:0] mode,
	input logic [63:0] x);
	FP64Word w;
	logic [127:0] man, ip, rem, half;
	logic [64:0] mag;
	logic [63:0] sat;
	logic up, bad;
	int e, sh;
	w.raw = x;
	if (sgn)
		sat = w.fp.sign ? 64'h8000_0000_0000_0000 : 64'h7FFF_FFFF_FFFF_FFFF;
	else
		sat = w.fp.sign ? 64'd0 : {64{1'b1}};
	if ((&w.fp.exp) && (|w.fp.sig))   // nan
		return {3'b010, sgn ? 64'h7FFF_FFFF_FFFF_FFFF : {64{1'b1}}};
	if (w.fp.exp >= 11'(`EXP_BIAS + 64))
		return {3'b011, sat};         // 2^64 and up including inf
	man = {75'd0, w.fp.exp != 0, w.fp.sig};
	e = w.fp.exp;
	e = e - (`EXP_BIAS + `FMSB + 1);  // weight of the lsb
	if (e >= 0) begin
		ip = man << e;
		rem = '0;
		half = 128'd1;
	end else begin
		sh = (-e > 120) ? 120 : -e;    // far below one so all sticky
		ip = man >> sh;
		rem = man & ((128'd1 << sh) - 1);
		half = 128'd1 << (sh - 1);
	end
	up = roundsUp(mode, w.fp.sign, ip[0], rem, half);
	mag = ip[64:0] + {64'd0, up};
	if (w.fp.sign)
		bad = sgn ? (mag > 65'h0_8000_0000_0000_0000) : (mag != 0);
	else
		bad = sgn ? (mag >= 65'h0_8000_0000_0000_0000) : mag[64];
	if (bad)
		return {3'b011, sat};
	return {rem != 0, 2'b00, w.fp.sign ? -mag[63:0] : mag[63:0]};
endfunction

// ============================================================
// expected values and checks
// ============================================================

always @(posedge clk) begin
	if (!rstN) begin
		chkValid <= 1'b0;
	end else if (ce) begin
		chkValid <= 1'b1;
		if (dir) begin
			{expInexact, expInvalid, expOverflow, expO} <= f2iModel(op, rm, i);
		end else begin
			{expInexact, expO} <= i2fModel(op, rm, i);
			expInvalid <= 1'b0;
			expOverflow <= 1'b0;
		end
	end
end

checkO: assert property (@(posedge clk) chkValid |-> o.raw == expO)
	else begin
		errCount = errCount + 1;
		$display("mismatch at %0t: o expected %h, got %h", $time, $sampled(expO),
			$sampled(o));
	end
checkInexact: assert property (@(posedge clk) chkValid |-> inexact == expInexact)
	else begin
		errCount = errCount + 1;
		$display("mismatch at %0t: inexact expected %b, got %b", $time,
			$sampled(expInexact), $sampled(inexact));
	end
checkInvalid: assert property (@(posedge clk) chkValid |-> invalid == expInvalid)
	else begin
		errCount = errCount + 1;
		$display("mismatch at %0t: invalid expected %b, got %b", $time,
			$sampled(expInvalid), $sampled(invalid));
	end
checkOverflow: assert property (@(posedge clk) chkValid |-> overflow == expOverflow)
	else begin
		errCount = errCount + 1;
		$display("mismatch at %0t: overflow expected %b, got %b", $time,
			$sampled(expOverflow), $sampled(overflow));
	end

// ============================================================
// stimulus
// ============================================================

task automatic driveOp(input logic d, input logic s, input logic [2:0] mode,
	input logic [63:0] x);
	@(negedge clk);
	dir = d;
	op = s;
	rm = mode;
	i = x;
	ce = 1'b1;
endtask

// let the last result reach its check and then report
task automatic endTest(input string name);
	@(negedge clk);
	ce = 1'b0;
	repeat (2) @(posedge clk);
	#1;
	if (errCount == testErrBase) begin
		passCount++;
		$display("test %s: ok", name);
	end else begin
		failCount++;
		$display("test %s: %0d errors", name, errCount - testErrBase);
	end
	testErrBase = errCount;
endtask

initial begin
	#(ClkPeriod * (RunCycles + 100));
	$display("timeout: the tests did not finish in the expected time");
	$display("=== FAIL ===");
	$finish;
end

initial begin
	rstN = 1'b0;
	ce = 1'b0;
	dir = 1'b0;
	op = 1'b0;
	rm = 3'd0;
	i = '0;
	repeat (5) @(negedge clk);
	rstN = 1'b1;

	// exact ints keep inexact at 0
	driveOp(0, 0, 0, 64'd0);
	driveOp(0, 0, 0, 64'd1);
	driveOp(0, 1, 1, 64'd1);
	driveOp(0, 1, 4, {64{1'b1}});                 // -1
	driveOp(0, 1, 0, 64'h8000_0000_0000_0000);    // -2^63
	driveOp(0, 0, 3, 64'h8000_0000_0000_0000);    // +2^63
	driveOp(0, 1, 0, -64'd1000);
	driveOp(0, 0, 0, 64'd123456789);
	driveOp(0, 1, 2, 64'd42);
	driveOp(0, 0, 4, 64'h001F_FFFF_FFFF_FFFF);    // 53 ones still exact
	for (k = 0; k < 64; k += 9)
		driveOp(0, k[0], 3'(k), 64'd1 << k);
	endTest("exact int to double");

	for (m = 0; m < 8; m++) begin
		for (n = 0; n < RoundPerMode; n++) begin
			rndW.raw = randBits(64);
			rndW.raw[60 + randBits(2)] = 1'b1;     // over 53 significant bits
			driveOp(0, 1'(randBits(1)), 3'(m), rndW.raw);
		end
	end
	driveOp(0, 0, 0, 64'h7FFF_FFFF_FFFF_FE00);    // tie on odd and the carry bumps exp
	driveOp(0, 0, 2, 64'h7FFF_FFFF_FFFF_FC01);
	driveOp(0, 1, 3, -64'h7FFF_FFFF_FFFF_FC01);
	endTest("rounded int to double");

	for (m = 0; m < 8; m++) begin
		for (k = 0; k < 2; k++) begin
			for (n = 0; n < RangePerCase; n++) begin
				rndW.fp.sign = k[0] & 1'(randBits(1));
				rndW.fp.exp = 11'(`EXP_BIAS - 2 + randBits(6));
				rndW.fp.sig = 52'(randBits(52));
				driveOp(1, k[0], 3'(m), rndW.raw);
			end
		end
	end
	endTest("in-range double to int");

	driveOp(1, 1, 0, 64'h7FF8_0000_0000_0000);    // quiet nan
	driveOp(1, 0, 0, 64'hFFF0_0000_0000_0001);
	driveOp(1, 1, 0, 64'h7FF0_0000_0000_0000);    // +inf
	driveOp(1, 0, 0, 64'h7FF0_0000_0000_0000);
	driveOp(1, 1, 0, 64'hFFF0_0000_0000_0000);    // -inf
	driveOp(1, 0, 0, 64'hFFF0_0000_0000_0000);
	driveOp(1, 0, 0, 64'h43F0_0000_0000_0000);    // 2^64
	driveOp(1, 1, 0, 64'hC3F0_0000_0000_0000);
	driveOp(1, 1, 0, 64'h43E0_0000_0000_0000);    // 2^63
	driveOp(1, 0, 0, 64'h43E0_0000_0000_0000);
	driveOp(1, 1, 0, 64'hC3E0_0000_0000_0000);
	driveOp(1, 0, 1, 64'hBFF8_0000_0000_0000);    // -1.5 unsigned
	driveOp(1, 0, 3, 64'hBFD0_0000_0000_0000);    // -0.25 down to -1
	driveOp(1, 0, 0, 64'hBFD0_0000_0000_0000);
	driveOp(1, 1, 0, 64'h4629_3E59_39A0_8CEA);    // about 1e30
	endTest("saturation");

	for (k = 0; k < AltCycles; k++) begin
		rndW.raw = randBits(64);
		if (k[0])
			rndW.fp.exp = 11'(`EXP_BIAS + randBits(5));
		driveOp(k[0], 1'(randBits(1)), 3'(randBits(3)), rndW.raw);
	end
	endTest("alternating direction");

	driveOp(0, 1, 0, -64'd7);
	repeat (5) begin
		@(negedge clk);
		ce = 1'b0;                                 // inputs move while outputs hold
		dir = 1'(randBits(1));
		rm = 3'(randBits(3));
		i = randBits(64);
	end
	@(negedge clk);
	rstN = 1'b0;
	@(negedge clk);
	rstN = 1'b1;
	@(negedge clk);
	driveOp(1, 1, 0, 64'h4045_0000_0000_0000);    // 42.0
	endTest("ce and reset");

	$display("tests passed %0d, failed %0d, check errors %0d", passCount, failCount,
		errCount);
	if (failCount == 0 && errCount == 0)
		$display("=== PASS ===");
	else
		$display("=== FAIL ===");
	$finish;
end

endmodule

//--- fpCvtUnit.f
+incdir+rtl
rtl/fp64Pkg.sv
rtl/cntlz64Reg.sv
rtl/fpCvtI64To64.sv
rtl/fpCvt64ToI64.sv
rtl/fpCvtUnit.sv
tests/fpCvtUnit_properties.sv
tests/fpCvtUnit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fpCvtUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f fpCvtUnit.f --top-module fpCvtUnit_tb -o fpCvtUnit_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

output=$(./obj_dir/fpCvtUnit_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
	exit 0
fi
echo "pass message not found"
exit 1
